// File: Makefile
# Verilator build and run for the SCSI DMA front end

VERILATOR  ?= verilator
TOP        ?= scsi_dma_tb
FILELIST   ?= scsi_dma.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert
SIM_ARGS   ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: hw/cpu_reg_port.sv
// CPU register access port
`timescale 1ns/10ps

module cpu_reg_port (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  logic                     cpu_req_valid,
    output logic                     cpu_req_ready,
    input  logic                     cpu_rw,
    input  scsi_dma_pkg::scsi_byte_t cpu_wdata,
    output logic                     cpu_rsp_valid,
    input  logic                     cpu_rsp_ready,
    output scsi_dma_pkg::scsi_byte_t cpu_rdata,
    output logic                     cpu_access,
    output logic                     cpu_write_dir,
    output logic                     cpu_dsack,
    output scsi_dma_pkg::scsi_byte_t held_wdata,
    input  logic                     set_dsack,
    input  scsi_dma_pkg::scsi_byte_t read_byte,
    input  logic                     read_byte_valid
);
    logic busy;     // From acceptance until the response is taken
    logic accept;
    logic rsp_done;
    logic rd_capture;

    assign cpu_req_ready = ~busy;
    assign accept        = cpu_req_valid & cpu_req_ready;
    assign rsp_done      = cpu_rsp_valid & cpu_rsp_ready;
    assign rd_capture    = read_byte_valid & busy & ~cpu_write_dir;

    always_ff @(posedge CLK) begin
        if (accept)
            held_wdata <= cpu_wdata;
        if (rd_capture)
            cpu_rdata <= read_byte;
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            busy          <= 1'b0;
            cpu_access    <= 1'b0;
            cpu_write_dir <= 1'b0;
            cpu_dsack     <= 1'b0;
            cpu_rsp_valid <= 1'b0;
        end else begin
            if (accept) begin
                busy          <= 1'b1;
                cpu_access    <= 1'b1;
                cpu_write_dir <= ~cpu_rw;
            end
            if (set_dsack) begin
                cpu_access <= 1'b0;
                cpu_dsack  <= 1'b1;
                if (cpu_write_dir)
                    cpu_rsp_valid <= 1'b1;
            end
            // A read answers once the lane has sampled the chip
            if (rd_capture)
                cpu_rsp_valid <= 1'b1;
            if (rsp_done) begin
                busy          <= 1'b0;
                cpu_dsack     <= 1'b0;
                cpu_rsp_valid <= 1'b0;
            end
        end
    end

endmodule

// File: hw/dma_fifo.sv
// Longword DMA FIFO
`timescale 1ns/10ps

module dma_fifo (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  logic                     host_in_valid,
    input  scsi_dma_pkg::longword_t  host_in_data,
    output logic                     host_in_ready,
    output logic                     host_out_valid,
    output scsi_dma_pkg::longword_t  host_out_data,
    input  logic                     host_out_ready,
    input  logic                     inc_bo,
    input  logic                     inc_ni,
    input  logic                     inc_no,
    input  logic                     rd_fifo,
    input  logic                     ri_fifo,
    input  logic                     byte_wr_en,
    input  scsi_dma_pkg::scsi_byte_t byte_wr_data,
    output scsi_dma_pkg::scsi_byte_t byte_rd_data,
    output logic                     fifo_full,
    output logic                     fifo_empty,
    output logic                     boeq3,
    output logic                     rd_busy,
    output logic                     ri_busy
);
    import scsi_dma_pkg::*;

    longword_t mem [FIFO_DEPTH];
    fifo_ptr_t next_in;
    fifo_ptr_t next_out;
    byte_ptr_t byte_ptr;
    fifo_cnt_t count;
    fifo_cnt_t count_next;
    logic      push;
    logic      pop;

    assign push = host_in_valid & host_in_ready;
    assign pop  = host_out_valid & host_out_ready;

    assign fifo_full      = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign fifo_empty     = (count == '0);
    assign host_in_ready  = ~fifo_full;
    assign host_out_valid = ~fifo_empty;
    assign host_out_data  = mem[next_out];
    assign byte_rd_data   = mem[next_out][{byte_ptr, 3'b000} +: 8];  // Head entry, current lane
    assign boeq3          = (byte_ptr == 2'd3);

    // Host push and SCSI byte commit can both add an entry
    always_comb begin
        count_next = count;
        if (push || ri_fifo)
            count_next = count_next + 1'b1;
        if (pop || rd_fifo)
            count_next = count_next - 1'b1;
    end

    always_ff @(posedge CLK) begin
        if (push)
            mem[next_in] <= host_in_data;
        else if (byte_wr_en)
            mem[next_in][{byte_ptr, 3'b000} +: 8] <= byte_wr_data;  // Assemble in next-in entry
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            next_in  <= '0;
            next_out <= '0;
            byte_ptr <= '0;
            count    <= '0;
            rd_busy  <= 1'b0;
            ri_busy  <= 1'b0;
        end else begin
            if (push || inc_ni)
                next_in <= next_in + 1'b1;
            if (pop || inc_no)
                next_out <= next_out + 1'b1;
            if (inc_bo)
                byte_ptr <= byte_ptr + 1'b1;    // Wraps after lane 3
            count   <= count_next;
            rd_busy <= rd_fifo;                 // Hold off next start while count settles
            ri_busy <= ri_fifo;
        end
    end

endmodule

// File: hw/scsi_byte_lane.sv
// SCSI pin and byte lane
`timescale 1ns/10ps

module scsi_byte_lane (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  logic                     cpu2s,
    input  logic                     s2cpu,
    input  logic                     f2s,
    input  logic                     s2f,
    input  logic                     re,
    input  logic                     we,
    input  logic                     cs,
    input  logic                     dack,
    input  scsi_dma_pkg::scsi_byte_t held_wdata,
    input  scsi_dma_pkg::scsi_byte_t byte_rd_data,
    input  logic                     scsi_drq,
    input  scsi_dma_pkg::scsi_byte_t scsi_din,
    output logic                     scsi_cs,
    output logic                     scsi_re,
    output logic                     scsi_we,
    output logic                     scsi_dack,
    output scsi_dma_pkg::scsi_byte_t scsi_dout,
    output logic                     drq_sync,
    output logic                     byte_wr_en,
    output scsi_dma_pkg::scsi_byte_t byte_wr_data,
    output scsi_dma_pkg::scsi_byte_t read_byte,
    output logic                     read_byte_valid
);
    import scsi_dma_pkg::*;

    logic [DREQ_SYNC_STAGES-1:0] drq_pipe;
    logic                        rd_end;    // Last cycle of the read pulse on the pin

    assign drq_sync     = drq_pipe[DREQ_SYNC_STAGES-1];
    assign rd_end       = scsi_re & ~re;
    assign byte_wr_en   = rd_end & s2f;
    assign byte_wr_data = scsi_din;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            drq_pipe        <= '0;
            scsi_cs         <= 1'b0;
            scsi_re         <= 1'b0;
            scsi_we         <= 1'b0;
            scsi_dack       <= 1'b0;
            read_byte_valid <= 1'b0;
        end else begin
            drq_pipe        <= {drq_pipe[DREQ_SYNC_STAGES-2:0], scsi_drq};
            scsi_cs         <= cs;
            scsi_re         <= re;
            scsi_we         <= we;
            scsi_dack       <= dack;
            read_byte_valid <= rd_end & s2cpu;
        end
    end

    always_ff @(posedge CLK) begin
        if (cpu2s)
            scsi_dout <= held_wdata;
        else if (f2s)
            scsi_dout <= byte_rd_data;      // Held stable past the write strobe
        if (rd_end && s2cpu)
            read_byte <= scsi_din;
    end

endmodule

// File: hw/scsi_dma_pkg.sv
// SCSI DMA shared definitions
package scsi_dma_pkg;

    typedef logic [31:0] longword_t;    // Host data word
    typedef logic [7:0]  scsi_byte_t;   // SCSI data byte
    typedef logic [2:0]  fifo_ptr_t;    // FIFO entry index
    typedef logic [1:0]  byte_ptr_t;    // Byte lane within a longword

    localparam int FIFO_DEPTH       = 8;
    localparam int FIFO_CNT_W       = $clog2(FIFO_DEPTH) + 1;
    localparam int DREQ_SYNC_STAGES = 2;

    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;  // Entry count up to FIFO_DEPTH

    // Sparse state encoding
    typedef enum logic [4:0] {
        IDLE_DMA_RD = 5'd0,     // Idle on the SCSI to FIFO side
        CPUREQ      = 5'd8,     // Start of a CPU register cycle
        IDLE_DMA_WR = 5'd16,    // Idle on the FIFO to SCSI side
        C2S_1       = 5'd17,
        C2S_2       = 5'd26,
        C2S_3       = 5'd6,
        C2S_4       = 5'd22,
        C2S_5       = 5'd14,
        F2S_1       = 5'd28,
        F2S_2       = 5'd2,
        F2S_3       = 5'd18,
        F2S_4       = 5'd1,
        S2C_1       = 5'd10,
        S2C_2       = 5'd30,
        S2C_3       = 5'd3,
        S2C_4       = 5'd19,
        S2C_5       = 5'd9,
        S2C_6       = 5'd25,
        S2F_1       = 5'd24,
        S2F_2       = 5'd4,
        S2F_3       = 5'd20,
        S2F_4       = 5'd12
    } scsi_state_t;

endpackage

// File: hw/scsi_dma_top.sv
// SCSI DMA front end
`timescale 1ns/10ps

module scsi_dma_top (
    input  logic                     CLK,
    input  logic                     nRESET,
    input  logic                     dmadir,
    input  logic                     host_in_valid,
    input  scsi_dma_pkg::longword_t  host_in_data,
    output logic                     host_in_ready,
    output logic                     host_out_valid,
    output scsi_dma_pkg::longword_t  host_out_data,
    input  logic                     host_out_ready,
    input  logic                     cpu_req_valid,
    output logic                     cpu_req_ready,
    input  logic                     cpu_rw,
    input  scsi_dma_pkg::scsi_byte_t cpu_wdata,
    output logic                     cpu_rsp_valid,
    input  logic                     cpu_rsp_ready,
    output scsi_dma_pkg::scsi_byte_t cpu_rdata,
    output logic                     scsi_cs,
    output logic                     scsi_re,
    output logic                     scsi_we,
    output logic                     scsi_dack,
    output scsi_dma_pkg::scsi_byte_t scsi_dout,
    input  logic                     scsi_drq,
    input  scsi_dma_pkg::scsi_byte_t scsi_din
);
    import scsi_dma_pkg::*;

    logic       cpu2s, s2cpu, f2s, s2f, re, we, cs, dack;
    logic       inc_bo, inc_ni, inc_no, rd_fifo, ri_fifo, set_dsack;
    logic       fifo_full, fifo_empty, boeq3, rd_busy, ri_busy;
    logic       cpu_access, cpu_write_dir, cpu_dsack, drq_sync;
    logic       byte_wr_en, read_byte_valid;
    scsi_byte_t byte_wr_data, byte_rd_data, held_wdata, read_byte;

    dma_fifo dma_fifo_i (.*);

    cpu_reg_port cpu_reg_port_i (.*);

    scsi_port_sm scsi_port_sm_i (.*);

    scsi_byte_lane scsi_byte_lane_i (.*);

endmodule

// File: hw/scsi_port_sm.sv
// SCSI transfer state machine
`timescale 1ns/10ps

module scsi_port_sm (
    input  logic CLK,
    input  logic nRESET,
    input  logic drq_sync,
    input  logic cpu_access,
    input  logic cpu_write_dir,
    input  logic cpu_dsack,
    input  logic dmadir,        // High moves SCSI to memory
    input  logic fifo_full,
    input  logic fifo_empty,
    input  logic boeq3,
    input  logic rd_busy,
    input  logic ri_busy,
    output logic cpu2s,
    output logic s2cpu,
    output logic f2s,
    output logic s2f,
    output logic re,
    output logic we,
    output logic cs,
    output logic dack,
    output logic inc_bo,
    output logic inc_ni,
    output logic inc_no,
    output logic rd_fifo,
    output logic ri_fifo,
    output logic set_dsack
);
    import scsi_dma_pkg::*;

    scsi_state_t state;
    scsi_state_t state_next;
    logic        start_s2f;
    logic        start_f2s;

    // CPU access wins over a pending DMA byte
    assign start_s2f = drq_sync & ~cpu_access & ~fifo_full & dmadir & ~ri_busy;
    assign start_f2s = drq_sync & ~cpu_access & ~fifo_empty & ~dmadir & ~rd_busy;

    always_comb begin
        state_next = state;
        case (state)
            IDLE_DMA_RD: begin
                if (start_s2f)
                    state_next = S2F_1;
                else if (cpu_access)
                    state_next = CPUREQ;
                else if (!dmadir)
                    state_next = IDLE_DMA_WR;
            end
            IDLE_DMA_WR: begin
                if (start_f2s)
                    state_next = F2S_1;
                else if (cpu_access)
                    state_next = CPUREQ;
                else
                    state_next = IDLE_DMA_RD;
            end
            CPUREQ:  state_next = cpu_write_dir ? C2S_1 : S2C_1;
            C2S_1:   state_next = C2S_2;
            C2S_2:   state_next = C2S_3;
            C2S_3:   state_next = C2S_4;
            C2S_4:   state_next = C2S_5;
            C2S_5:   state_next = cpu_dsack ? C2S_5 : IDLE_DMA_RD;    // Wait for termination
            S2C_1:   state_next = S2C_2;
            S2C_2:   state_next = S2C_3;
            S2C_3:   state_next = S2C_4;
            S2C_4:   state_next = S2C_5;
            S2C_5:   state_next = S2C_6;
            S2C_6:   state_next = cpu_dsack ? S2C_6 : IDLE_DMA_RD;
            F2S_1:   state_next = F2S_2;
            F2S_2:   state_next = F2S_3;
            F2S_3:   state_next = F2S_4;
            F2S_4:   state_next = IDLE_DMA_WR;
            S2F_1:   state_next = S2F_2;
            S2F_2:   state_next = S2F_3;
            S2F_3:   state_next = S2F_4;
            S2F_4:   state_next = IDLE_DMA_RD;
            default: state_next = IDLE_DMA_RD;
        endcase
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET)
            state <= IDLE_DMA_RD;
        else
            state <= state_next;
    end

    always_comb begin
        cpu2s     = 1'b0;
        s2cpu     = 1'b0;
        f2s       = 1'b0;
        s2f       = 1'b0;
        re        = 1'b0;
        we        = 1'b0;
        cs        = 1'b0;
        dack      = 1'b0;
        inc_bo    = 1'b0;
        inc_ni    = 1'b0;
        inc_no    = 1'b0;
        rd_fifo   = 1'b0;
        ri_fifo   = 1'b0;
        set_dsack = 1'b0;
        case (state)
            IDLE_DMA_RD: dack = start_s2f;      // Acknowledge leads the byte by one cycle
            IDLE_DMA_WR: dack = start_f2s;
            CPUREQ: begin
                cs    = 1'b1;
                re    = ~cpu_write_dir;
                s2cpu = ~cpu_write_dir;
                we    = cpu_write_dir;
                cpu2s = cpu_write_dir;
            end
            C2S_1, C2S_2: begin
                cs    = 1'b1;
                cpu2s = 1'b1;
                we    = 1'b1;
            end
            C2S_3: begin
                cs        = 1'b1;
                cpu2s     = 1'b1;
                set_dsack = 1'b1;
            end
            S2C_1, S2C_2: begin
                cs    = 1'b1;
                re    = 1'b1;
                s2cpu = 1'b1;
            end
            S2C_3: begin
                cs        = 1'b1;
                re        = 1'b1;
                s2cpu     = 1'b1;
                set_dsack = 1'b1;
            end
            S2C_4: begin
                re    = 1'b1;
                s2cpu = 1'b1;
            end
            S2C_5, S2C_6: s2cpu = 1'b1;         // Keep data path toward the CPU
            F2S_1, F2S_2, F2S_3: begin
                we   = 1'b1;
                f2s  = 1'b1;
                dack = 1'b1;
            end
            F2S_4: begin
                inc_bo  = 1'b1;
                inc_no  = boeq3;                // Last lane retires the head entry
                rd_fifo = boeq3;
            end
            S2F_1, S2F_2, S2F_3: begin
                re   = 1'b1;
                s2f  = 1'b1;
                dack = 1'b1;
            end
            S2F_4: begin
                s2f     = 1'b1;                 // Byte is written into the FIFO here
                inc_bo  = 1'b1;
                inc_ni  = boeq3;
                ri_fifo = boeq3;
            end
            default: ;
        endcase
    end

endmodule

// File: scsi_dma.f
hw/scsi_dma_pkg.sv
hw/dma_fifo.sv
hw/cpu_reg_port.sv
hw/scsi_port_sm.sv
hw/scsi_byte_lane.sv
hw/scsi_dma_top.sv
tests/scsi_dma_chk.sv
tests/scsi_dma_tb.sv

// File: tests/scsi_dma_chk.sv
// SCSI DMA protocol checks
`timescale 1ns/10ps

module scsi_dma_chk (
    input  logic                      CLK,
    input  logic                      nRESET,
    input  logic                      re,
    input  logic                      we,
    input  logic                      cs,
    input  logic                      dack,
    input  logic                      fifo_full,
    input  logic                      fifo_empty,
    input  scsi_dma_pkg::scsi_state_t state
);
    import scsi_dma_pkg::*;

    int fail_count = 0;     // Failed assertion count

    // The pins follow these strobes one cycle later
    rd_wr_excl: assert property (@(posedge CLK) disable iff (!nRESET) !(re && we))
        else begin
            fail_count++;
            $error("Read and write strobes high together");
        end

    dack_vs_cs: assert property (@(posedge CLK) disable iff (!nRESET) !($rose(dack) && cs))
        else begin
            fail_count++;
            $error("DMA acknowledge rose during a chip select cycle");
        end

    full_vs_empty: assert property (@(posedge CLK) disable iff (!nRESET)
                                    !(fifo_full && fifo_empty))
        else begin
            fail_count++;
            $error("FIFO full and empty at the same time");
        end

    byte_to_idle: assert property (@(posedge CLK) disable iff (!nRESET)
                                   (state == S2F_4 || state == F2S_4) |=>
                                   (state == IDLE_DMA_RD || state == IDLE_DMA_WR))
        else begin
            fail_count++;
            $error("Last DMA byte state not followed by an idle state");
        end

endmodule

bind scsi_port_sm scsi_dma_chk sm_chk_i (
    .CLK        (CLK),
    .nRESET     (nRESET),
    .re         (re),
    .we         (we),
    .cs         (cs),
    .dack       (dack),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .state      (state)
);

// File: tests/scsi_dma_tb.sv
// SCSI DMA testbench
`timescale 1ns/10ps

module scsi_dma_tb;
    import scsi_dma_pkg::*;

    localparam int STREAM_WORDS = 8;
    localparam int STREAM_BYTES = 4 * STREAM_WORDS;
    localparam int CPU_OPS      = 8;
    localparam int CYCLE_LIMIT  = 40 * (3 * STREAM_BYTES) + 60 * (3 * CPU_OPS) + 200;

    logic       CLK;
    logic       nRESET;
    logic       dmadir;
    logic       host_in_valid;
    longword_t  host_in_data;
    logic       host_in_ready;
    logic       host_out_valid;
    longword_t  host_out_data;
    logic       host_out_ready;
    logic       cpu_req_valid;
    logic       cpu_req_ready;
    logic       cpu_rw;
    scsi_byte_t cpu_wdata;
    logic       cpu_rsp_valid;
    logic       cpu_rsp_ready;
    scsi_byte_t cpu_rdata;
    logic       scsi_cs;
    logic       scsi_re;
    logic       scsi_we;
    logic       scsi_dack;
    scsi_byte_t scsi_dout;
    logic       scsi_drq;
    scsi_byte_t scsi_din;

    integer     seed;
    int         cycle_count;
    int         drq_pending;            // Bytes the chip still requests
    scsi_byte_t chip_reg;               // Chip data register
    scsi_byte_t exp_reg;
    scsi_byte_t src_q[$];               // Bytes the chip offers toward memory
    scsi_byte_t exp_sink_q[$];          // Bytes the chip should receive
    longword_t  in_words[$];            // Longwords still to push
    longword_t  exp_words[$];           // Longwords the host should pop
    logic [8:0] cpu_ops[$];             // {read, data}
    logic       cpu_busy;
    logic       cur_rd;
    logic       rand_reg;               // Chip loads a new register value per read
    logic       prev_re;
    logic       prev_we;
    logic       prev_dack;

    scsi_dma_top scsi_dma_top_i (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_longword(input string name, input longword_t exp, input longword_t act);
        if (exp !== act)
            stop_with_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_byte(input string name, input scsi_byte_t exp, input scsi_byte_t act);
        if (exp !== act)
            stop_with_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            stop_with_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    function automatic logic random_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic scsi_byte_t random_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic int assert_failures();
        return scsi_dma_top_i.scsi_port_sm_i.sm_chk_i.fail_count;
    endfunction

    // Chip model with DACK selecting the DMA byte on the data bus
    task automatic chip_cycle();
        if (scsi_dack && !prev_dack) begin
            if (drq_pending == 0)
                stop_with_error("DUT acknowledged a DMA byte that the chip never requested");
            else
                drq_pending--;      // Drop DREQ early for the last byte
        end
        if (prev_we && !scsi_we) begin
            if (scsi_cs)
                chip_reg = scsi_dout;                                   // Register write
            else if (exp_sink_q.size() == 0)
                stop_with_error("Chip received a DMA byte that was never sent");
            else
                check_byte("m2s_byte", exp_sink_q.pop_front(), scsi_dout);
        end
        if (prev_re && !scsi_re && prev_dack) begin
            if (src_q.size() == 0)
                stop_with_error("DUT read a DMA byte that the chip did not offer");
            else
                src_q.delete(0);
        end
        scsi_drq  = (drq_pending > 0);
        scsi_din  = (scsi_dack && src_q.size() > 0) ? src_q[0] : chip_reg;
        prev_re   = scsi_re;
        prev_we   = scsi_we;
        prev_dack = scsi_dack;
    endtask

    // Handshakes are decided here and complete at the next edge
    task automatic host_cycle();
        host_in_valid  = 1'b0;
        host_out_ready = 1'b0;
        if (!dmadir && in_words.size() > 0 && host_in_ready && random_bit()) begin
            host_in_valid = 1'b1;
            host_in_data  = in_words.pop_front();
        end
        if (dmadir) begin
            host_out_ready = random_bit();
            if (host_out_valid && host_out_ready) begin
                if (exp_words.size() == 0)
                    stop_with_error("Host received a longword that the chip never sent");
                else
                    check_longword("s2m_word", exp_words.pop_front(), host_out_data);
            end
        end
    endtask

    task automatic cpu_cycle();
        logic [8:0] op;
        cpu_req_valid = 1'b0;
        cpu_rsp_ready = 1'b0;
        check_bit("cpu_req_ready", !cpu_busy, cpu_req_ready);  // Busy until the response is taken
        if (!cpu_busy && cpu_ops.size() > 0 && cpu_req_ready && random_bit()) begin
            op            = cpu_ops.pop_front();
            cur_rd        = op[8];
            cpu_req_valid = 1'b1;
            cpu_rw        = op[8];
            cpu_wdata     = op[7:0];
            cpu_busy      = 1'b1;
            if (!op[8]) begin
                exp_reg = op[7:0];
            end else if (rand_reg) begin
                chip_reg = random_byte();
                exp_reg  = chip_reg;
            end
        end
        if (cpu_rsp_valid && scsi_dack)
            stop_with_error("DMA acknowledge while a CPU response was pending");
        else if (cpu_rsp_valid && !cpu_busy)
            stop_with_error("CPU response without an accepted request");
        else if (cpu_rsp_valid) begin
            cpu_rsp_ready = random_bit();
            if (cpu_rsp_ready) begin
                if (cur_rd)
                    check_byte("cpu_read", exp_reg, cpu_rdata);
                else
                    check_byte("cpu_write", exp_reg, chip_reg);
                cpu_busy = 1'b0;
            end
        end
    endtask

    task automatic step();
        @(posedge CLK);
        #1;
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT)
            stop_with_error($sformatf("Timeout after %0d cycles", cycle_count));
        else if (assert_failures() != 0)
            stop_with_error("A bound protocol assertion failed");
        else begin
            chip_cycle();
            host_cycle();
            cpu_cycle();
        end
    endtask

    task automatic load_chip_source(input int n);
        scsi_byte_t b[4];
        for (int i = 0; i < n / 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                b[j] = random_byte();
                src_q.push_back(b[j]);
            end
            exp_words.push_back({b[3], b[2], b[1], b[0]});     // Byte 0 arrives first
        end
        drq_pending += n;
    endtask

    task automatic load_host_words(input int n);
        longword_t w;
        for (int i = 0; i < n; i++) begin
            w = {random_byte(), random_byte(), random_byte(), random_byte()};
            in_words.push_back(w);
            for (int j = 0; j < 4; j++)
                exp_sink_q.push_back(w[8*j +: 8]);
        end
        drq_pending += 4 * n;
    endtask

    task automatic queue_cpu_ops(input int n, input int kind);
        logic rd;
        for (int i = 0; i < n; i++) begin
            rd = (kind == 2) ? random_bit() : (kind == 1);  // 0 write, 1 read, 2 mixed
            cpu_ops.push_back({rd, random_byte()});
        end
    endtask

    task automatic run_until_idle();
        while (src_q.size() > 0 || exp_words.size() > 0 || in_words.size() > 0 ||
               exp_sink_q.size() > 0 || cpu_ops.size() > 0 || cpu_busy)
            step();
        step();
    endtask

    initial begin
        seed           = 32'h1e35_d5d9;
        nRESET         = 1'b0;
        dmadir         = 1'b1;
        host_in_valid  = 1'b0;
        host_in_data   = '0;
        host_out_ready = 1'b0;
        cpu_req_valid  = 1'b0;
        cpu_rw         = 1'b0;
        cpu_wdata      = '0;
        cpu_rsp_ready  = 1'b0;
        scsi_drq       = 1'b0;
        scsi_din       = '0;
        cycle_count    = 0;
        drq_pending    = 0;
        chip_reg       = 8'h5a;
        exp_reg        = 8'h5a;
        cpu_busy       = 1'b0;
        cur_rd         = 1'b0;
        rand_reg       = 1'b0;
        prev_re        = 1'b0;
        prev_we        = 1'b0;
        prev_dack      = 1'b0;
        repeat (8) @(posedge CLK);
        #1 nRESET = 1'b1;

        // Idle after reset
        check_bit("reset_cs", 1'b0, scsi_cs);
        check_bit("reset_re", 1'b0, scsi_re);
        check_bit("reset_we", 1'b0, scsi_we);
        check_bit("reset_dack", 1'b0, scsi_dack);
        check_bit("reset_out_valid", 1'b0, host_out_valid);
        check_bit("reset_rsp_valid", 1'b0, cpu_rsp_valid);
        check_bit("reset_in_ready", 1'b1, host_in_ready);

        // SCSI to memory stream
        load_chip_source(STREAM_BYTES);
        run_until_idle();
        check_bit("s2m_drained", 1'b0, host_out_valid);

        // Memory to SCSI stream
        dmadir = 1'b0;
        load_host_words(STREAM_WORDS);
        run_until_idle();
        check_bit("m2s_drained", 1'b0, host_out_valid);
        check_bit("m2s_in_ready", 1'b1, host_in_ready);

        queue_cpu_ops(CPU_OPS, 0);
        run_until_idle();
        rand_reg = 1'b1;
        queue_cpu_ops(CPU_OPS, 1);
        run_until_idle();

        // CPU accesses during a running stream
        rand_reg = 1'b0;
        dmadir   = 1'b1;
        load_chip_source(STREAM_BYTES);
        queue_cpu_ops(CPU_OPS, 2);
        run_until_idle();
        check_bit("mixed_drained", 1'b0, host_out_valid);

        if (assert_failures() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            stop_with_error("A bound protocol assertion failed at the end of the run");
        end
    end

endmodule
